//--- address_decoder.sv
`timescale 1ns/1ns
`include "pet_defines.svh"

module address_decoder import pet_bus_pkg::*; (
    input  bus_req_t  req_i,
    input  logic      phi2_i,
    input  logic      strobe_win_i,   // RAM OE/WE window inside phi2
    output chip_sel_t sel_o
);

    logic [15:0] a;
    logic        hi_bank;             // A16 set, plain RAM in the upper bank
    logic        is_ram;
    logic        is_vram;
    logic        is_rom;
    logic        is_io;
    logic        is_mem;
    logic        wr_ok;

    assign a       = req_i.addr[15:0];
    assign hi_bank = req_i.addr[16];

    assign is_ram  = hi_bank || (a <= `PET_RAM_TOP);
    assign is_vram = !hi_bank && (a >= `PET_VRAM_START) && (a <= `PET_VRAM_END);
    assign is_io   = !hi_bank && (a >= `PET_IO_START) && (a <= `PET_IO_END);
    assign is_rom  = !hi_bank && (((a >= `PET_ROM1_START) && (a <= `PET_ROM1_END))
                                  || (a >= `PET_ROM2_START));
    assign is_mem  = is_ram | is_vram | is_rom;   // Everything the RAM chip serves

    // ROM image lives in RAM, only the MCU may load it
    assign wr_ok = !is_rom || req_i.from_mcu;

    always_comb begin
        sel_o.ram_ce  = phi2_i && is_mem;
        sel_o.ram_oe  = phi2_i && strobe_win_i && is_mem && req_i.rw_n;
        sel_o.ram_we  = phi2_i && strobe_win_i && is_mem && !req_i.rw_n && wr_ok;

        // 16-byte windows in the I/O page
        sel_o.pia1_cs = phi2_i && is_io && ((a & `PET_IO_DEV_MASK) == `PET_PIA1_BASE);
        sel_o.pia2_cs = phi2_i && is_io && ((a & `PET_IO_DEV_MASK) == `PET_PIA2_BASE);
        sel_o.via_cs  = phi2_i && is_io && ((a & `PET_IO_DEV_MASK) == `PET_VIA_BASE);
        sel_o.io_oe   = phi2_i && is_io;

        // 1 KB of video RAM repeats four times across 8000-8FFF
        sel_o.ram_addr_11_10 = is_vram ? 2'b00 : a[11:10];
    end

endmodule

//--- bus_timing.sv
`timescale 1ns/1ns
`include "pet_defines.svh"

module bus_timing import pet_bus_pkg::*, pet_ctrl_pkg::*; (
    input  logic       clk16_i,
    input  logic       rst_n_i,
    input  logic       cmd_valid_i,
    input  spi_cmd_t   cmd_i,
    input  bus_data_t  bus_data_i,
    output cycle_cnt_t cycle_o,
    output logic       phi2_o,
    output logic       strobe_win_o,
    output logic       mcu_slot_o,     // MCU owns the current bus cycle
    output logic       cpu_clk_o,
    output logic       cpu_be_o,
    output logic       cpu_ready_o,
    output logic       addr_oe_o,
    output logic       data_oe_o,
    output logic       spi_ready_o,
    output bus_data_t  rd_data_o,
    output logic       rd_valid_o,
    output bus_req_t   mcu_req_o
);

    cycle_cnt_t    cycle_q;
    access_state_t state_q;
    spi_cmd_t      cmd_q;              // Accepted request
    logic          spi_ready_q;
    logic          rd_valid_q;
    bus_data_t     rd_data_q;
    logic          last_cycle;
    logic          accept;
    logic          capture;

    assign last_cycle = (cycle_q == cycle_cnt_t'(`PET_CYCLE_LEN - 1));
    assign accept     = cmd_valid_i && (state_q == ACC_IDLE || state_q == ACC_DONE);
    assign capture    = (state_q == ACC_ACTIVE) && !cmd_q.write
                        && (cycle_q == `PET_CAPTURE_CYCLE);

    // Free-running bus cycle position
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i)
            cycle_q <= '0;
        else if (last_cycle)
            cycle_q <= '0;
        else
            cycle_q <= cycle_q + 4'd1;
    end

    // MCU access slot
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            state_q     <= ACC_IDLE;
            spi_ready_q <= 1'b0;       // Stays low until the first access ends
            rd_valid_q  <= 1'b0;
        end else begin
            rd_valid_q <= capture;
            unique case (state_q)
                ACC_IDLE: begin
                    if (accept) begin
                        state_q     <= ACC_PENDING;
                        spi_ready_q <= 1'b0;
                    end
                end
                ACC_PENDING: if (last_cycle) state_q <= ACC_ACTIVE;  // Slot opens at cycle 0
                ACC_ACTIVE: begin
                    if (cycle_q == cycle_cnt_t'(`PET_CYCLE_LEN - 2)) begin
                        state_q     <= ACC_DONE;
                        spi_ready_q <= 1'b1;   // High from cycle 15
                    end
                end
                ACC_DONE: begin
                    state_q <= accept ? ACC_PENDING : ACC_IDLE;
                    if (accept)
                        spi_ready_q <= 1'b0;
                end
                default: state_q <= ACC_IDLE;
            endcase
        end
    end

    // Request and read data
    always_ff @(posedge clk16_i) begin
        if (accept)
            cmd_q <= cmd_i;
        if (capture)
            rd_data_q <= bus_data_i;
    end

    assign cycle_o      = cycle_q;
    assign phi2_o       = (cycle_q >= `PET_PHI2_START);
    assign strobe_win_o = (cycle_q >= `PET_RAM_STROBE_START) && (cycle_q <= `PET_RAM_STROBE_END);
    assign mcu_slot_o   = (state_q == ACC_ACTIVE) || (state_q == ACC_DONE);
    assign cpu_clk_o    = phi2_o;             // Low 0-7, high 8-15
    assign cpu_be_o     = !mcu_slot_o;        // CPU floats its bus for the slot
    assign cpu_ready_o  = !mcu_slot_o;        // and holds its state
    assign addr_oe_o    = mcu_slot_o;
    assign data_oe_o    = mcu_slot_o && cmd_q.write && phi2_o;
    assign spi_ready_o  = spi_ready_q;
    assign rd_data_o    = rd_data_q;
    assign rd_valid_o   = rd_valid_q;

    assign mcu_req_o = '{addr: cmd_q.addr, data: cmd_q.data,
                         rw_n: !cmd_q.write, from_mcu: 1'b1};

endmodule

//--- list.f
+incdir+.
pet_bus_pkg.sv
pet_ctrl_pkg.sv
spi_cmd_receiver.sv
address_decoder.sv
bus_timing.sv
main.sv
top.sv
top_properties.sv
tb_top.sv

//--- main.sv
`timescale 1ns/1ns

module main import pet_bus_pkg::*, pet_ctrl_pkg::*; (
    input  logic        clk16_i,
    input  logic        rst_n_i,
    input  logic        spi_sck_i,
    input  logic        spi_cs_n_i,
    input  logic        spi_mosi_i,
    output logic        spi_miso_o,
    output logic        spi_miso_oe_o,
    input  logic [15:0] bus_addr_i,     // CPU drives A15-A0 only
    input  bus_data_t   bus_data_i,
    input  logic        bus_rw_n_i,
    output bus_addr_t   bus_addr_o,
    output logic        bus_addr_oe_o,
    output bus_data_t   bus_data_o,
    output logic        bus_data_oe_o,
    output logic        bus_rw_n_o,
    output logic        bus_rw_n_oe_o,
    output logic        cpu_clk_o,
    output logic        cpu_be_o,
    output logic        cpu_ready_o,
    output logic        spi_ready_o,
    output logic        ram_ce_o,
    output logic        ram_oe_o,
    output logic        ram_we_o,
    output logic [11:10] ram_addr_o,
    output logic        pia1_cs_o,
    output logic        pia2_cs_o,
    output logic        via_cs_o,
    output logic        io_oe_o
);

    cycle_cnt_t cycle;                  // Bus cycle position, for observation
    logic       phi2;
    logic       strobe_win;
    logic       mcu_slot;
    logic       addr_oe;
    logic       data_oe;
    logic       cmd_valid;
    logic       rd_valid;
    spi_cmd_t   cmd;
    bus_data_t  rd_data;
    bus_req_t   mcu_req;
    bus_req_t   cpu_req;
    bus_req_t   req;                    // Whoever owns this bus cycle
    chip_sel_t  sel;

    spi_cmd_receiver spi_rx (
        .clk16_i, .rst_n_i, .spi_sck_i, .spi_cs_n_i, .spi_mosi_i,
        .rd_data_i(rd_data), .rd_valid_i(rd_valid),
        .spi_miso_o, .spi_miso_oe_o,
        .cmd_valid_o(cmd_valid), .cmd_o(cmd)
    );

    bus_timing timing (
        .clk16_i, .rst_n_i,
        .cmd_valid_i(cmd_valid), .cmd_i(cmd), .bus_data_i,
        .cycle_o(cycle), .phi2_o(phi2), .strobe_win_o(strobe_win), .mcu_slot_o(mcu_slot),
        .cpu_clk_o, .cpu_be_o, .cpu_ready_o,
        .addr_oe_o(addr_oe), .data_oe_o(data_oe), .spi_ready_o,
        .rd_data_o(rd_data), .rd_valid_o(rd_valid), .mcu_req_o(mcu_req)
    );

    assign cpu_req = '{addr: {1'b0, bus_addr_i}, data: bus_data_i,
                       rw_n: bus_rw_n_i, from_mcu: 1'b0};
    assign req     = mcu_slot ? mcu_req : cpu_req;

    address_decoder decode (
        .req_i(req), .phi2_i(phi2), .strobe_win_i(strobe_win), .sel_o(sel)
    );

    // Bus drivers, enabled only during an MCU slot
    assign bus_addr_o    = req.addr;    // A16 low for the CPU
    assign bus_addr_oe_o = addr_oe;
    assign bus_data_o    = req.data;
    assign bus_data_oe_o = data_oe;
    assign bus_rw_n_o    = req.rw_n;
    assign bus_rw_n_oe_o = addr_oe;

    assign ram_ce_o   = sel.ram_ce;
    assign ram_oe_o   = sel.ram_oe;
    assign ram_we_o   = sel.ram_we;
    assign ram_addr_o = sel.ram_addr_11_10;
    assign pia1_cs_o  = sel.pia1_cs;
    assign pia2_cs_o  = sel.pia2_cs;
    assign via_cs_o   = sel.via_cs;
    assign io_oe_o    = sel.io_oe;

endmodule

//--- pet_bus_pkg.sv
package pet_bus_pkg;

    typedef logic [16:0] bus_addr_t;    // A16 only reachable from the MCU
    typedef logic [7:0]  bus_data_t;
    typedef logic [3:0]  cycle_cnt_t;   // Position inside the 16-tick bus cycle

    // Access currently on the bus
    typedef struct packed {
        bus_addr_t addr;
        bus_data_t data;
        logic      rw_n;                // 0 = write, 1 = read
        logic      from_mcu;            // Set while the MCU owns the slot
    } bus_req_t;

    // Decoded strobes and selects, all active high
    typedef struct packed {
        logic       ram_ce;
        logic       ram_oe;
        logic       ram_we;
        logic       pia1_cs;
        logic       pia2_cs;
        logic       via_cs;
        logic       io_oe;
        logic [1:0] ram_addr_11_10;     // Forced low in the video window
    } chip_sel_t;

endpackage

//--- pet_ctrl_pkg.sv
package pet_ctrl_pkg;

    import pet_bus_pkg::*;

    // One complete request from the MCU
    typedef struct packed {
        logic      write;
        bus_addr_t addr;
        bus_data_t data;                // Unused for reads
    } spi_cmd_t;

    // MCU access slot
    typedef enum logic [1:0] {
        ACC_IDLE,                       // Nothing queued
        ACC_PENDING,                    // Waiting for the next bus cycle start
        ACC_ACTIVE,                     // Own the bus, cycles 0 to 14
        ACC_DONE                        // Last cycle of the slot, ready raised
    } access_state_t;

    typedef logic [1:0] spi_byte_idx_t; // Command, addr hi, addr lo, data

endpackage

//--- pet_defines.svh
`ifndef PET_DEFINES_SVH
`define PET_DEFINES_SVH

// Bus cycle, counted in clk16 ticks
`define PET_CYCLE_LEN         16
`define PET_PHI2_START        4'd8      // CPU clock high from here to the end
`define PET_RAM_STROBE_START  4'd10     // RAM OE/WE window, inclusive
`define PET_RAM_STROBE_END    4'd14
`define PET_CAPTURE_CYCLE     4'd14     // MCU read data latched here

// Address map of the lower 64 KB bank
`define PET_RAM_TOP           16'h7FFF
`define PET_VRAM_START        16'h8000  // 4 KB window, mirrored onto 1 KB
`define PET_VRAM_END          16'h8FFF
`define PET_ROM1_START        16'h9000
`define PET_ROM1_END          16'hE7FF
`define PET_ROM2_START        16'hF000  // Runs to the top of the bank
`define PET_IO_START          16'hE800
`define PET_IO_END            16'hE8FF
`define PET_PIA1_BASE         16'hE810
`define PET_PIA2_BASE         16'hE820
`define PET_VIA_BASE          16'hE840
`define PET_IO_DEV_MASK       16'hFFF0  // Each I/O chip spans 16 bytes

`endif

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_top -f list.f -o tb_top

sim_out=$(./obj_dir/tb_top || true)
echo "$sim_out"

if grep -qx "Test OK" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- spi_cmd_receiver.sv
`timescale 1ns/1ns

module spi_cmd_receiver import pet_bus_pkg::*, pet_ctrl_pkg::*; (
    input  logic      clk16_i,
    input  logic      rst_n_i,
    input  logic      spi_sck_i,
    input  logic      spi_cs_n_i,
    input  logic      spi_mosi_i,
    input  bus_data_t rd_data_i,        // Byte read by the last MCU access
    input  logic      rd_valid_i,
    output logic      spi_miso_o,
    output logic      spi_miso_oe_o,
    output logic      cmd_valid_o,      // One-tick strobe, no back-pressure
    output spi_cmd_t  cmd_o
);

    logic [2:0]    sck_q;               // Two sync stages plus edge history
    logic [2:0]    cs_q;
    logic [1:0]    mosi_q;
    logic          sck_rise;
    logic          sck_fall;
    logic          cs_rise;
    logic          cs_low;
    logic          byte_done;
    logic [7:0]    rx_byte;
    logic [2:0]    bit_cnt_q;
    spi_byte_idx_t byte_idx_q;
    logic [6:0]    shift_q;
    logic          complete_q;          // Enough bytes for the command type
    logic          cmd_valid_q;
    spi_cmd_t      cmd_q;
    bus_data_t     rd_q;
    bus_data_t     miso_sr_q;

    assign sck_rise  = sck_q[1] & ~sck_q[2];
    assign sck_fall  = ~sck_q[1] & sck_q[2];
    assign cs_rise   = cs_q[1] & ~cs_q[2];  // End of transaction
    assign cs_low    = ~cs_q[1];
    assign byte_done = cs_low & sck_rise & (bit_cnt_q == 3'd7);
    assign rx_byte   = {shift_q, mosi_q[1]};   // Last bit joins on its own edge

    // Pin synchronizers
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            sck_q  <= '0;
            cs_q   <= '1;               // Deselected
            mosi_q <= '0;
        end else begin
            sck_q  <= {sck_q[1:0], spi_sck_i};
            cs_q   <= {cs_q[1:0], spi_cs_n_i};
            mosi_q <= {mosi_q[0], spi_mosi_i};
        end
    end

    // Bit and byte framing, cleared while deselected
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i || !cs_low) begin
            bit_cnt_q  <= '0;
            byte_idx_q <= '0;
            complete_q <= 1'b0;
        end else if (sck_rise) begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) begin
                if (byte_idx_q != 2'd3)
                    byte_idx_q <= byte_idx_q + 2'd1;  // Extra bytes pile up on the last
                if (byte_idx_q == 2'd3 || (byte_idx_q == 2'd2 && !cmd_q.write))
                    complete_q <= 1'b1;
            end
        end
    end

    // Strobe lands two ticks after the synchronized CS_N edge
    always_ff @(posedge clk16_i) begin
        if (!rst_n_i)
            cmd_valid_q <= 1'b0;
        else
            cmd_valid_q <= cs_rise & complete_q;  // Short transactions drop here
    end

    // Command assembly, MSB first
    always_ff @(posedge clk16_i) begin
        if (cs_low && sck_rise)
            shift_q <= {shift_q[5:0], mosi_q[1]};
        if (byte_done) begin
            case (byte_idx_q)
                2'd0: begin
                    cmd_q.write    <= rx_byte[7];
                    cmd_q.addr[16] <= rx_byte[0];
                end
                2'd1: cmd_q.addr[15:8] <= rx_byte;
                2'd2: cmd_q.addr[7:0]  <= rx_byte;
                default: if (!complete_q) cmd_q.data <= rx_byte;  // Only the first data byte
            endcase
        end
    end

    // Read data goes back during the first byte of the next transaction
    always_ff @(posedge clk16_i) begin
        if (rd_valid_i)
            rd_q <= rd_data_i;
        if (!cs_low)
            miso_sr_q <= rd_q;          // MSB already on MISO when CS_N falls
        else if (sck_fall)
            miso_sr_q <= {miso_sr_q[6:0], 1'b0};  // Mode 0, change on falling SCK
    end

    assign spi_miso_o    = miso_sr_q[7];
    assign spi_miso_oe_o = cs_low;
    assign cmd_valid_o   = cmd_valid_q;
    assign cmd_o         = cmd_q;

endmodule

//--- tb_top.sv
`timescale 1ns/1ns

module tb_top import pet_bus_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst_n;
    logic        spi_sck, spi_cs_n, spi_mosi;
    logic        spi_miso, spi_miso_oe, spi_ready_n;
    logic [15:0] bus_addr_in, bus_addr_out, bus_addr_oe;
    logic        bus_addr_16;
    logic [7:0]  bus_data_in, bus_data_out, bus_data_oe;
    logic        bus_rw_n_in, bus_rw_n_out, bus_rw_oe;
    logic        cpu_clk, cpu_res_n_in, cpu_res_n_out, cpu_res_oe, cpu_ready, cpu_be;
    logic        cpu_irq_n, cpu_irq_oe, cpu_nmi_n, cpu_nmi_oe;
    logic        ram_ce_n, ram_oe_n, ram_we_n;
    logic [1:0]  ram_addr;
    logic        pia1_cs_n, pia2_cs_n, via_cs_n, io_oe_n;

    int          checks;
    int          errors;
    int          timeouts;
    logic        abort;                 // Set on a timeout, stops the golden loop
    int          run_len;               // Current cpu_clk phase length in clk16 ticks
    logic        first_run;
    logic        prev_cpu_clk;

    always #4 clk = ~clk;               // 8 ns period

    top DUT (
        .clk16_i(clk), .rst_n_i(rst_n),
        .spi1_sck_i(spi_sck), .spi1_cs_ni(spi_cs_n), .spi1_mcu_tx_i(spi_mosi),
        .spi1_mcu_rx_o(spi_miso), .spi1_mcu_rx_oe_o(spi_miso_oe), .spi_ready_no(spi_ready_n),
        .bus_addr_15_0_i(bus_addr_in), .bus_addr_15_0_o(bus_addr_out),
        .bus_addr_15_0_oe_o(bus_addr_oe), .bus_addr_16_o(bus_addr_16),
        .bus_data_7_0_i(bus_data_in), .bus_data_7_0_o(bus_data_out),
        .bus_data_7_0_oe_o(bus_data_oe),
        .bus_rw_ni(bus_rw_n_in), .bus_rw_no(bus_rw_n_out), .bus_rw_oe_o(bus_rw_oe),
        .cpu_clk_o(cpu_clk), .cpu_res_ni(cpu_res_n_in), .cpu_res_no(cpu_res_n_out),
        .cpu_res_oe_o(cpu_res_oe), .cpu_ready_o(cpu_ready),
        .cpu_irq_no(cpu_irq_n), .cpu_irq_oe_o(cpu_irq_oe),
        .cpu_nmi_no(cpu_nmi_n), .cpu_nmi_oe_o(cpu_nmi_oe), .cpu_be_o(cpu_be),
        .ram_ce_no(ram_ce_n), .ram_oe_no(ram_oe_n), .ram_we_no(ram_we_n), .ram_addr_o(ram_addr),
        .pia1_cs2_no(pia1_cs_n), .pia2_cs2_no(pia2_cs_n), .via_cs2_no(via_cs_n),
        .io_oe_no(io_oe_n)
    );

    // Inputs change 1 ns after the edge, outputs are read at the same point
    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic expect_hex(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        abort = 1'b1;
        $display("Timeout while waiting for %s", what);
    endtask

    // Stops at cycle 8 of the bus cycle
    task automatic wait_phi2_start();
        logic prev;
        int   n;
        prev = cpu_clk;
        for (n = 0; n < 40; n++) begin
            tick(1);
            if (!prev && cpu_clk)
                return;
            prev = cpu_clk;
        end
        report_timeout("the rising edge of cpu_clk_o");
    endtask

    task automatic wait_slot_start();
        int n;
        for (n = 0; n < 40; n++) begin
            if (!cpu_be)
                return;
            tick(1);
        end
        report_timeout("the MCU bus slot");
    endtask

    task automatic wait_spi_ready();
        int n;
        for (n = 0; n < 40; n++) begin
            if (!spi_ready_n)
                return;
            tick(1);
        end
        report_timeout("spi_ready_no to fall");
    endtask

    task automatic spi_begin();
        spi_cs_n = 1'b0;
        tick(5);
    endtask

    // Strobe is out three ticks after CS_N rises, slot not open yet
    task automatic spi_end();
        tick(3);
        spi_cs_n = 1'b1;
        tick(4);
    endtask

    // Mode 0, MSB first, five ticks per SCK half period
    task automatic spi_xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
        int i;
        for (i = 7; i >= 0; i--) begin
            spi_mosi = tx[i];
            tick(5);
            rx[i]   = spi_miso;         // Sampled as SCK rises
            spi_sck = 1'b1;
            tick(5);
            spi_sck = 1'b0;
        end
    endtask

    task automatic send_cmd(input logic write, input logic [16:0] addr,
                            input logic [7:0] data);
        logic [7:0] rx;
        spi_begin();
        spi_xfer_byte({write, 6'b0, addr[16]}, rx);
        spi_xfer_byte(addr[15:8], rx);
        spi_xfer_byte(addr[7:0], rx);
        if (write)
            spi_xfer_byte(data, rx);
        spi_end();
    endtask

    // Bus ownership at cycle 0 of the slot
    task automatic check_slot_bus(input logic [16:0] addr, input logic rw_n);
        expect_hex("cpu_be_o", 32'(cpu_be), 0);
        expect_hex("cpu_ready_o", 32'(cpu_ready), 0);
        expect_hex("bus_addr", 32'({bus_addr_16, bus_addr_out}), 32'(addr));
        expect_hex("bus_addr_15_0_oe_o", 32'(bus_addr_oe), 32'hFFFF);
        expect_hex("bus_rw_no", 32'(bus_rw_n_out), 32'(rw_n));
        expect_hex("bus_rw_oe_o", 32'(bus_rw_oe), 1);
        expect_hex("bus_data_7_0_oe_o", 32'(bus_data_oe), 0);   // Not before phi2
    endtask

    task automatic cpu_access(input logic [15:0] addr, input logic rw_n, input chip_sel_t exp);
        chip_sel_t got;
        bus_addr_in = addr;
        bus_rw_n_in = rw_n;
        wait_phi2_start();
        if (abort)
            return;
        tick(3);                        // Cycle 11, inside the RAM strobe window
        got = {~ram_ce_n, ~ram_oe_n, ~ram_we_n, ~pia1_cs_n, ~pia2_cs_n, ~via_cs_n,
               ~io_oe_n, ram_addr};
        expect_hex("cpu_be_o", 32'(cpu_be), 1);
        expect_hex("bus_addr_15_0_oe_o", 32'(bus_addr_oe), 0);
        expect_hex("sel {ce,oe,we,pia1,pia2,via,io,a11_10}", 32'(got), 32'(exp));
    endtask

    task automatic mcu_write(input logic [16:0] addr, input logic [7:0] data,
                             input logic we_exp);
        send_cmd(1'b1, addr, data);
        wait_slot_start();
        if (abort)
            return;
        check_slot_bus(addr, 1'b0);
        tick(11);
        expect_hex("bus_data_7_0_o", 32'(bus_data_out), 32'(data));
        expect_hex("bus_data_7_0_oe_o", 32'(bus_data_oe), 32'hFF);
        expect_hex("ram_we_no", 32'(ram_we_n), 32'(!we_exp));
        wait_spi_ready();
    endtask

    task automatic mcu_read(input logic [16:0] addr, input logic [7:0] drive,
                            input logic [7:0] miso_exp);
        logic [7:0] rx;
        send_cmd(1'b0, addr, 8'h00);
        wait_slot_start();
        if (abort)
            return;
        bus_data_in = drive;            // Memory answers during the slot
        check_slot_bus(addr, 1'b1);
        tick(11);
        expect_hex("bus_data_7_0_oe_o", 32'(bus_data_oe), 0);
        wait_spi_ready();
        bus_data_in = ~drive;
        if (abort)
            return;
        // One byte only, too short to become a command
        spi_begin();
        expect_hex("spi1_mcu_rx_oe_o", 32'(spi_miso_oe), 1);
        spi_xfer_byte(8'h00, rx);
        spi_end();
        expect_hex("spi1_mcu_rx_o byte", 32'(rx), 32'(miso_exp));
    endtask

    // CPU RES pulled low only while the core is in reset
    task automatic check_reset_hold();
        expect_hex("cpu_res_oe_o", 32'(cpu_res_oe), 1);
        expect_hex("cpu_res_no", 32'(cpu_res_n_out), 0);
    endtask

    task automatic check_reset_state();
        expect_hex("spi_ready_no", 32'(spi_ready_n), 1);
        expect_hex("cpu_be_o", 32'(cpu_be), 1);
        expect_hex("cpu_ready_o", 32'(cpu_ready), 1);
        expect_hex("ram {ce,oe,we}_no", 32'({ram_ce_n, ram_oe_n, ram_we_n}), 32'h7);
        expect_hex("io {pia1,pia2,via,io_oe}_no",
                   32'({pia1_cs_n, pia2_cs_n, via_cs_n, io_oe_n}), 32'hF);
        expect_hex("bus_addr_15_0_oe_o", 32'(bus_addr_oe), 0);
        expect_hex("bus_data_7_0_oe_o", 32'(bus_data_oe), 0);
        expect_hex("bus_rw_oe_o", 32'(bus_rw_oe), 0);
        expect_hex("spi1_mcu_rx_oe_o", 32'(spi_miso_oe), 0);
        expect_hex("cpu_res_oe_o", 32'(cpu_res_oe), 0);
        expect_hex("cpu_res_no", 32'(cpu_res_n_out), 1);
        expect_hex("cpu_irq {no,oe_o}", 32'({cpu_irq_n, cpu_irq_oe}), 32'h2);  // Idle, released
        expect_hex("cpu_nmi {no,oe_o}", 32'({cpu_nmi_n, cpu_nmi_oe}), 32'h2);
    endtask

    // CPU clock must keep an 8 high, 8 low shape
    always @(negedge clk) begin
        if (!rst_n) begin
            run_len   = 0;
            first_run = 1'b1;
        end else if (cpu_clk == prev_cpu_clk) begin
            run_len++;
        end else begin
            if (!first_run) begin
                checks++;
                if (run_len != 8) begin
                    errors++;
                    $display("FAILED cpu_clk_o phase length: got %0h, expected %0h", run_len, 8);
                end
            end
            first_run = 1'b0;
            run_len   = 1;
        end
        prev_cpu_clk = cpu_clk;
    end

    initial begin
        int               fd;
        int               n;
        int               steps;
        logic [7:0]       kind;
        logic [8*160-1:0] rest;
        logic [31:0]      g_addr, g_rw, g_ce, g_oe, g_we, g_p1, g_p2, g_via, g_io, g_ra;

        rst_n        = 1'b0;
        spi_sck      = 1'b0;
        spi_cs_n     = 1'b1;
        spi_mosi     = 1'b0;
        bus_addr_in  = 16'h0000;
        bus_data_in  = 8'h00;
        bus_rw_n_in  = 1'b1;
        cpu_res_n_in = 1'b1;            // Nobody else pulls RES
        checks       = 0;
        errors       = 0;
        timeouts     = 0;
        abort        = 1'b0;
        steps        = 0;

        repeat (15) @(posedge clk);
        #1 check_reset_hold();
        @(posedge clk);
        #1 rst_n = 1'b1;
        tick(1);
        check_reset_state();

        fd = $fopen("top_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open top_golden.txt");
        end
        while (fd != 0 && !abort) begin
            n = $fscanf(fd, "%s", kind);
            if (n != 1)
                break;
            if (kind == "#") begin
                n = $fgets(rest, fd);   // Column notes
            end else if (kind == "C") begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", g_addr, g_rw, g_ce, g_oe,
                            g_we, g_p1, g_p2, g_via, g_io, g_ra);
                cpu_access(g_addr[15:0], g_rw[0], {g_ce[0], g_oe[0], g_we[0], g_p1[0],
                           g_p2[0], g_via[0], g_io[0], g_ra[1:0]});
                steps++;
            end else if (kind == "W") begin
                n = $fscanf(fd, "%h %h %h", g_addr, g_rw, g_we);
                mcu_write(g_addr[16:0], g_rw[7:0], g_we[0]);
                steps++;
            end else if (kind == "R") begin
                n = $fscanf(fd, "%h %h %h", g_addr, g_rw, g_we);
                mcu_read(g_addr[16:0], g_rw[7:0], g_we[7:0]);
                steps++;
            end else begin
                errors++;
                $display("Unknown line kind in top_golden.txt");
                break;
            end
        end
        if (fd != 0)
            $fclose(fd);
        if (steps == 0 && fd != 0) begin
            errors++;
            $display("No stimulus lines found in top_golden.txt");
        end

        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- top.sv
`timescale 1ns/1ns

module top (
    input  logic         clk16_i,           // 16 MHz from the PLL
    input  logic         rst_n_i,

    // SPI to the MCU
    input  logic         spi1_sck_i,
    input  logic         spi1_cs_ni,
    input  logic         spi1_mcu_tx_i,     // MOSI
    output logic         spi1_mcu_rx_o,     // MISO
    output logic         spi1_mcu_rx_oe_o,  // Driven only while selected
    output logic         spi_ready_no,      // Low when the last command is done

    // System bus
    input  logic [15:0]  bus_addr_15_0_i,
    output logic [15:0]  bus_addr_15_0_o,
    output logic [15:0]  bus_addr_15_0_oe_o,
    output logic         bus_addr_16_o,     // Output only, the CPU has no A16
    input  logic [7:0]   bus_data_7_0_i,
    output logic [7:0]   bus_data_7_0_o,
    output logic [7:0]   bus_data_7_0_oe_o,
    input  logic         bus_rw_ni,         // 0 = write
    output logic         bus_rw_no,
    output logic         bus_rw_oe_o,

    // CPU
    output logic         cpu_clk_o,
    input  logic         cpu_res_ni,        // Open drain, wired-or
    output logic         cpu_res_no,
    output logic         cpu_res_oe_o,
    output logic         cpu_ready_o,       // 0 = halt
    output logic         cpu_irq_no,
    output logic         cpu_irq_oe_o,
    output logic         cpu_nmi_no,
    output logic         cpu_nmi_oe_o,
    output logic         cpu_be_o,          // 0 = CPU bus floats

    // RAM
    output logic         ram_ce_no,
    output logic         ram_oe_no,
    output logic         ram_we_no,
    output logic [11:10] ram_addr_o,        // Intercepted for video mirroring

    // I/O
    output logic         pia1_cs2_no,
    output logic         pia2_cs2_no,
    output logic         via_cs2_no,
    output logic         io_oe_no
);

    logic bus_addr_oe;
    logic bus_data_oe;
    logic cpu_res_o;
    logic core_rst_n;
    logic spi_ready_o;
    logic ram_ce_o, ram_oe_o, ram_we_o;
    logic pia1_cs_o, pia2_cs_o, via_cs_o, io_oe_o;

    assign bus_addr_15_0_oe_o = {16{bus_addr_oe}};  // One enable per pin
    assign bus_data_7_0_oe_o  = {8{bus_data_oe}};

    // Hold the CPU in reset with the core, and follow an external RES too
    assign cpu_res_o    = !rst_n_i;
    assign cpu_res_no   = !cpu_res_o;
    assign cpu_res_oe_o = cpu_res_o;                // Drive the wired-or only when asserting
    assign core_rst_n   = rst_n_i && cpu_res_ni;

    // IRQ and NMI never asserted
    assign cpu_irq_no   = 1'b1;
    assign cpu_irq_oe_o = 1'b0;
    assign cpu_nmi_no   = 1'b1;
    assign cpu_nmi_oe_o = 1'b0;

    assign spi_ready_no = !spi_ready_o;
    assign ram_ce_no    = !ram_ce_o;
    assign ram_oe_no    = !ram_oe_o;
    assign ram_we_no    = !ram_we_o;
    assign pia1_cs2_no  = !pia1_cs_o;
    assign pia2_cs2_no  = !pia2_cs_o;
    assign via_cs2_no   = !via_cs_o;
    assign io_oe_no     = !io_oe_o;

    main core (
        .clk16_i, .rst_n_i(core_rst_n),
        .spi_sck_i(spi1_sck_i), .spi_cs_n_i(spi1_cs_ni), .spi_mosi_i(spi1_mcu_tx_i),
        .spi_miso_o(spi1_mcu_rx_o), .spi_miso_oe_o(spi1_mcu_rx_oe_o),
        .bus_addr_i(bus_addr_15_0_i), .bus_data_i(bus_data_7_0_i), .bus_rw_n_i(bus_rw_ni),
        .bus_addr_o({bus_addr_16_o, bus_addr_15_0_o}), .bus_addr_oe_o(bus_addr_oe),
        .bus_data_o(bus_data_7_0_o), .bus_data_oe_o(bus_data_oe),
        .bus_rw_n_o(bus_rw_no), .bus_rw_n_oe_o(bus_rw_oe_o),
        .cpu_clk_o, .cpu_be_o, .cpu_ready_o, .spi_ready_o,
        .ram_ce_o, .ram_oe_o, .ram_we_o, .ram_addr_o,
        .pia1_cs_o, .pia2_cs_o, .via_cs_o, .io_oe_o
    );

endmodule

//--- top_golden.txt
# C addr rw ce oe we pia1 pia2 via io_oe ram_a11_10 is a CPU access with expected selects
# W addr data we is an MCU write and R addr bus_byte miso_byte an MCU read
C 1C34 1 1 1 0 0 0 0 0 3
C 1C34 0 1 0 1 0 0 0 0 3
C 7FFF 1 1 1 0 0 0 0 0 3
C 8C00 1 1 1 0 0 0 0 0 0
C 8400 0 1 0 1 0 0 0 0 0
C 8FFF 1 1 1 0 0 0 0 0 0
C 9800 1 1 1 0 0 0 0 0 2
C 9800 0 1 0 0 0 0 0 0 2
C F400 0 1 0 0 0 0 0 0 1
C E812 1 0 0 0 1 0 0 1 2
C E823 0 0 0 0 0 1 0 1 2
C E84F 1 0 0 0 0 0 1 1 2
C E880 1 0 0 0 0 0 0 1 2
C E900 1 0 0 0 0 0 0 0 2
W 09800 5A 1
C 9800 0 1 0 0 0 0 0 0 2
W 11234 A5 1
W 0E900 33 0
R 01C34 C3 C3
R 18000 7E 7E
C 0400 1 1 1 0 0 0 0 0 1

//--- top_properties.sv
`timescale 1ns/1ns
`include "pet_defines.svh"

module top_properties import pet_bus_pkg::*; (
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       cmd_valid_i,
    input logic       spi_ready_i,
    input logic       cpu_be_i,
    input cycle_cnt_t cycle_i,
    input logic       ram_we_i
);

    logic busy_q;                       // Command taken, access not finished yet

    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            busy_q <= 1'b0;
        else if (cmd_valid_i)
            busy_q <= 1'b1;
        else if (spi_ready_i)
            busy_q <= 1'b0;
    end

    // MCU has to wait for spi_ready
    cmd_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cmd_valid_i |-> !(busy_q && !spi_ready_i))
        else $error("command strobe while the previous access is still running");

    // CPU loses the bus only for a command in flight
    be_only_for_command: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !cpu_be_i |-> busy_q)
        else $error("cpu_be_o low without an MCU command in flight");

    slot_at_cycle_0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(cpu_be_i) |-> (cycle_i == '0))
        else $error("MCU slot opened away from cycle 0");

    slot_ends_at_cycle_0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(cpu_be_i) |-> (cycle_i == '0))   // Slot spans whole bus cycles
        else $error("MCU slot closed away from a bus cycle boundary");

    we_in_window: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ram_we_i |-> (cycle_i >= `PET_RAM_STROBE_START) && (cycle_i <= `PET_RAM_STROBE_END))
        else $error("ram_we outside the strobe window");

endmodule

bind main top_properties props (
    .clk_i(clk16_i), .rst_n_i(rst_n_i), .cmd_valid_i(cmd_valid), .spi_ready_i(spi_ready_o),
    .cpu_be_i(cpu_be_o), .cycle_i(cycle), .ram_we_i(ram_we_o)
);
